// File: include/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// datapath widths
`define EX_XLEN        32
`define EX_REG_ADDR_W  5
`define EX_UOP_W       6

// return address registers, x1 (ra) and x5 (t0)
`define EX_LINK_REG_A  1
`define EX_LINK_REG_B  5

// bytes per instruction, no compressed support
`define EX_INSN_STEP   4

`endif

// File: hw/ex_pkg.sv
`include "ex_settings.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]       word_t;
    typedef logic [2*`EX_XLEN-1:0]     dword_t;   // full product
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [`EX_UOP_W-1:0] {
        // arithmetic and logic
        ADDI, ADD, SUB, LUI, AUIPC,
        SLTI, SLTIU, SLT, SLTU,
        ANDI, ORI, XORI, AND, OR, XOR,
        // shifts
        SLLI, SRLI, SRAI, SLL, SRL, SRA,
        // multiply
        MUL, MULH, MULHU, MULHSU,
        // control flow
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // loads
        LB, LH, LW, LBU, LHU,
        // stores
        SB, SH, SW,
        NOP
    } uop_e;

    // x1 or x5 used as return address register
    function automatic logic is_link_reg(input reg_addr_t addr);
        return (addr == reg_addr_t'(`EX_LINK_REG_A)) ||
               (addr == reg_addr_t'(`EX_LINK_REG_B));
    endfunction

    function automatic logic is_load(input uop_e uop);
        return uop inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic is_store(input uop_e uop);
        return uop inside {SB, SH, SW};
    endfunction

endpackage

// File: hw/ex_operand_if.sv
`timescale 1ns/1ps

// one decoded uop and its operands, fanned out to the compute units
interface ex_operand_if;
    import ex_pkg::*;

    uop_e  uop;
    word_t rs1_d;
    word_t rs2_d;
    word_t imm;
    word_t pc;

    modport src (
        output uop, rs1_d, rs2_d, imm, pc
    );

    // units only look at the operands
    modport unit (
        input uop, rs1_d, rs2_d, imm, pc
    );

endinterface

// File: hw/ex_alu.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_alu (
    ex_operand_if.unit    ops_i,
    output ex_pkg::word_t alu_result_o
);
    import ex_pkg::*;

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0] shamt_reg;
    logic [SHAMT_W-1:0] shamt_imm;
    word_t              rs1_add_imm;
    word_t              rs1_add_rs2;
    word_t              rs1_sub_rs2;
    logic               lt_imm_s;
    logic               lt_imm_u;
    logic               lt_rs2_s;
    logic               lt_rs2_u;

    assign shamt_reg = ops_i.rs2_d[SHAMT_W-1:0];
    assign shamt_imm = ops_i.imm[SHAMT_W-1:0];

    assign rs1_add_imm = ops_i.rs1_d + ops_i.imm;
    assign rs1_add_rs2 = ops_i.rs1_d + ops_i.rs2_d;
    assign rs1_sub_rs2 = ops_i.rs1_d - ops_i.rs2_d;

    // set-less-than compares
    assign lt_imm_s = $signed(ops_i.rs1_d) < $signed(ops_i.imm);
    assign lt_imm_u = ops_i.rs1_d < ops_i.imm;
    assign lt_rs2_s = $signed(ops_i.rs1_d) < $signed(ops_i.rs2_d);
    assign lt_rs2_u = ops_i.rs1_d < ops_i.rs2_d;

    always_comb begin
        case (ops_i.uop)
            ADDI:    alu_result_o = rs1_add_imm;
            ADD:     alu_result_o = rs1_add_rs2;
            SUB:     alu_result_o = rs1_sub_rs2;
            LUI:     alu_result_o = ops_i.imm;          // imm already shifted by decode
            AUIPC:   alu_result_o = ops_i.pc + ops_i.imm;
            SLTI:    alu_result_o = word_t'(lt_imm_s);
            SLTIU:   alu_result_o = word_t'(lt_imm_u);
            SLT:     alu_result_o = word_t'(lt_rs2_s);
            SLTU:    alu_result_o = word_t'(lt_rs2_u);
            ANDI:    alu_result_o = ops_i.rs1_d & ops_i.imm;
            ORI:     alu_result_o = ops_i.rs1_d | ops_i.imm;
            XORI:    alu_result_o = ops_i.rs1_d ^ ops_i.imm;
            AND:     alu_result_o = ops_i.rs1_d & ops_i.rs2_d;
            OR:      alu_result_o = ops_i.rs1_d | ops_i.rs2_d;
            XOR:     alu_result_o = ops_i.rs1_d ^ ops_i.rs2_d;
            SLLI:    alu_result_o = ops_i.rs1_d << shamt_imm;
            SRLI:    alu_result_o = ops_i.rs1_d >> shamt_imm;
            SRAI:    alu_result_o = word_t'($signed(ops_i.rs1_d) >>> shamt_imm);
            SLL:     alu_result_o = ops_i.rs1_d << shamt_reg;
            SRL:     alu_result_o = ops_i.rs1_d >> shamt_reg;
            SRA:     alu_result_o = word_t'($signed(ops_i.rs1_d) >>> shamt_reg);  // sign fill
            default: alu_result_o = '0;                 // not an alu uop
        endcase
    end

endmodule

// File: hw/ex_branch.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_branch (
    ex_operand_if.unit        ops_i,
    input  ex_pkg::reg_addr_t rs1_a_i,
    input  ex_pkg::reg_addr_t rd_a_i,
    input  ex_pkg::word_t     next_pc_i,     // predicted next pc from fetch
    input  logic              next_taken_i,  // predicted direction
    output ex_pkg::word_t     link_result_o,
    output logic              request_o,
    output logic              taken_o,
    output logic              is_call_o,
    output logic              is_ret_o,
    output logic              is_jmp_o,
    output ex_pkg::word_t     target_o,
    output logic              redirect_o,
    output ex_pkg::word_t     redirect_pc_o
);
    import ex_pkg::*;

    word_t pc_step;
    word_t pc_add_imm;
    logic  rs_eq;
    logic  rs_lt_s;
    logic  rs_lt_u;
    logic  rd_link;
    logic  rs1_link;

    assign pc_step    = ops_i.pc + word_t'(`EX_INSN_STEP);
    assign pc_add_imm = ops_i.pc + ops_i.imm;

    assign rs_eq   = ops_i.rs1_d == ops_i.rs2_d;
    assign rs_lt_s = $signed(ops_i.rs1_d) < $signed(ops_i.rs2_d);
    assign rs_lt_u = ops_i.rs1_d < ops_i.rs2_d;

    assign rd_link  = is_link_reg(rd_a_i);
    assign rs1_link = is_link_reg(rs1_a_i);

    always_comb begin
        request_o     = 1'b0;
        taken_o       = 1'b0;
        is_call_o     = 1'b0;
        is_ret_o      = 1'b0;
        is_jmp_o      = 1'b0;
        target_o      = '0;
        link_result_o = '0;
        case (ops_i.uop)
            JAL: begin
                request_o     = 1'b1;
                taken_o       = 1'b1;
                target_o      = pc_add_imm;
                link_result_o = pc_step;
                is_call_o     = rd_link;    // push only when rd is x1/x5
                is_jmp_o      = !rd_link;
            end
            JALR: begin
                request_o     = 1'b1;
                taken_o       = 1'b1;
                target_o      = ops_i.rs1_d + ops_i.imm;
                link_result_o = pc_step;
                if (rd_link) begin
                    is_call_o = 1'b1;
                    // different link regs on both sides means pop then push
                    is_ret_o  = rs1_link && (rd_a_i != rs1_a_i);
                end else if (rs1_link) begin
                    is_ret_o = 1'b1;
                end else begin
                    is_jmp_o = 1'b1;
                end
            end
            BEQ:  {request_o, taken_o, target_o} = {1'b1, rs_eq, pc_add_imm};
            BNE:  {request_o, taken_o, target_o} = {1'b1, !rs_eq, pc_add_imm};
            BLT:  {request_o, taken_o, target_o} = {1'b1, rs_lt_s, pc_add_imm};
            BGE:  {request_o, taken_o, target_o} = {1'b1, !rs_lt_s, pc_add_imm};
            BLTU: {request_o, taken_o, target_o} = {1'b1, rs_lt_u, pc_add_imm};
            BGEU: {request_o, taken_o, target_o} = {1'b1, !rs_lt_u, pc_add_imm};
            default: begin
            end
        endcase
    end

    // misprediction check against the fetch stage guess
    always_comb begin
        redirect_o    = 1'b0;
        redirect_pc_o = '0;
        if (request_o) begin
            if (taken_o) begin
                if (!next_taken_i || (next_pc_i != target_o)) begin
                    redirect_o    = 1'b1;
                    redirect_pc_o = target_o;
                end
            end else if (next_taken_i) begin
                redirect_o    = 1'b1;
                redirect_pc_o = pc_step;    // fall through
            end
        end
    end

endmodule

// File: hw/ex_mul.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_mul (
    ex_operand_if.unit    ops_i,
    output ex_pkg::word_t mul_result_o
);
    import ex_pkg::*;

    localparam int MSB = `EX_XLEN - 1;

    logic   rs1_neg;
    logic   rs2_neg;
    logic   neg_result;
    word_t  op_a;
    word_t  op_b;
    dword_t product;
    dword_t product_neg;

    // which operands get turned into magnitudes
    always_comb begin
        rs1_neg = 1'b0;
        rs2_neg = 1'b0;
        case (ops_i.uop)
            MULH: begin
                rs1_neg = ops_i.rs1_d[MSB];
                rs2_neg = ops_i.rs2_d[MSB];
            end
            MULHSU: rs1_neg = ops_i.rs1_d[MSB];   // rs2 stays unsigned
            default: begin
            end
        endcase
    end

    assign op_a = rs1_neg ? (~ops_i.rs1_d + word_t'(1)) : ops_i.rs1_d;
    assign op_b = rs2_neg ? (~ops_i.rs2_d + word_t'(1)) : ops_i.rs2_d;

    assign product     = dword_t'(op_a) * dword_t'(op_b);
    assign product_neg = ~product + dword_t'(1);
    assign neg_result  = rs1_neg ^ rs2_neg;

    always_comb begin
        case (ops_i.uop)
            MUL:     mul_result_o = product[MSB:0];
            MULHU:   mul_result_o = product[2*`EX_XLEN-1:`EX_XLEN];
            MULH, MULHSU: begin
                mul_result_o = neg_result ? product_neg[2*`EX_XLEN-1:`EX_XLEN]
                                          : product[2*`EX_XLEN-1:`EX_XLEN];
            end
            default: mul_result_o = '0;
        endcase
    end

endmodule

// File: hw/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  ex_pkg::uop_e      uop_i,
    input  ex_pkg::word_t     rs1_d_i,
    input  ex_pkg::word_t     rs2_d_i,
    input  ex_pkg::word_t     imm_i,
    input  logic              rd_we_i,
    input  ex_pkg::reg_addr_t rd_a_i,
    input  ex_pkg::word_t     alu_result_i,
    input  ex_pkg::word_t     link_result_i,
    input  ex_pkg::word_t     mul_result_i,
    input  logic              branch_request_i,
    input  logic              branch_taken_i,
    input  logic              branch_is_call_i,
    input  logic              branch_is_ret_i,
    input  logic              branch_is_jmp_i,
    input  ex_pkg::word_t     branch_target_i,
    input  logic              redirect_i,
    input  ex_pkg::word_t     redirect_pc_i,
    output logic              valid_o,
    output logic              rd_we_o,
    output ex_pkg::reg_addr_t rd_a_o,
    output ex_pkg::word_t     rd_wd_o,
    output ex_pkg::uop_e      uop_o,
    output ex_pkg::word_t     mem_a_o,
    output ex_pkg::word_t     mem_wd_o,
    output logic              branch_request_o,
    output logic              branch_taken_o,
    output logic              branch_is_call_o,
    output logic              branch_is_ret_o,
    output logic              branch_is_jmp_o,
    output ex_pkg::word_t     branch_target_o,
    output logic              redirect_o,
    output ex_pkg::word_t     redirect_pc_o
);
    import ex_pkg::*;

    word_t mem_a;
    word_t mem_wd;
    word_t result;

    // address for loads and stores, data for stores only
    assign mem_a  = (is_load(uop_i) || is_store(uop_i)) ? (rs1_d_i + imm_i) : '0;
    assign mem_wd = is_store(uop_i) ? rs2_d_i : '0;

    // units give zero on foreign uops so a plain or is enough
    assign result = alu_result_i | link_result_i | mul_result_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o          <= 1'b0;
            rd_we_o          <= 1'b0;
            branch_request_o <= 1'b0;
            branch_taken_o   <= 1'b0;
            branch_is_call_o <= 1'b0;
            branch_is_ret_o  <= 1'b0;
            branch_is_jmp_o  <= 1'b0;
            redirect_o       <= 1'b0;
        end else begin
            valid_o          <= valid_i;
            rd_we_o          <= valid_i & rd_we_i;
            branch_request_o <= valid_i & branch_request_i;
            branch_taken_o   <= valid_i & branch_taken_i;
            branch_is_call_o <= valid_i & branch_is_call_i;
            branch_is_ret_o  <= valid_i & branch_is_ret_i;
            branch_is_jmp_o  <= valid_i & branch_is_jmp_i;
            redirect_o       <= valid_i & redirect_i;   // bubbles never redirect
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        rd_a_o          <= rd_a_i;
        rd_wd_o         <= result;
        uop_o           <= uop_i;     // lsu decodes access size from this
        mem_a_o         <= mem_a;
        mem_wd_o        <= mem_wd;
        branch_target_o <= branch_target_i;
        redirect_pc_o   <= redirect_pc_i;
    end

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  ex_pkg::uop_e      uop_i,
    input  ex_pkg::word_t     pc_i,
    input  ex_pkg::word_t     rs1_d_i,
    input  ex_pkg::word_t     rs2_d_i,
    input  ex_pkg::word_t     imm_i,
    input  ex_pkg::word_t     next_pc_i,
    input  logic              next_taken_i,
    input  logic              rd_we_i,
    input  ex_pkg::reg_addr_t rs1_a_i,
    input  ex_pkg::reg_addr_t rd_a_i,
    output logic              valid_o,
    output logic              rd_we_o,
    output ex_pkg::reg_addr_t rd_a_o,
    output ex_pkg::word_t     rd_wd_o,
    output ex_pkg::uop_e      uop_o,
    output ex_pkg::word_t     mem_a_o,
    output ex_pkg::word_t     mem_wd_o,
    output logic              branch_request_o,
    output logic              branch_taken_o,
    output logic              branch_is_call_o,
    output logic              branch_is_ret_o,
    output logic              branch_is_jmp_o,
    output ex_pkg::word_t     branch_target_o,
    output logic              redirect_o,
    output ex_pkg::word_t     redirect_pc_o
);
    import ex_pkg::*;

    word_t alu_result;
    word_t link_result;
    word_t mul_result;
    logic  br_request;
    logic  br_taken;
    logic  br_is_call;
    logic  br_is_ret;
    logic  br_is_jmp;
    word_t br_target;
    logic  br_redirect;
    word_t br_redirect_pc;

    ex_operand_if ops ();

    // operands go straight to the units, no register here
    assign ops.uop   = uop_i;
    assign ops.rs1_d = rs1_d_i;
    assign ops.rs2_d = rs2_d_i;
    assign ops.imm   = imm_i;
    assign ops.pc    = pc_i;

    ex_alu u_alu (
        .ops_i        (ops),
        .alu_result_o (alu_result)
    );

    ex_branch u_branch (
        .ops_i         (ops),
        .rs1_a_i       (rs1_a_i),
        .rd_a_i        (rd_a_i),
        .next_pc_i     (next_pc_i),
        .next_taken_i  (next_taken_i),
        .link_result_o (link_result),
        .request_o     (br_request),
        .taken_o       (br_taken),
        .is_call_o     (br_is_call),
        .is_ret_o      (br_is_ret),
        .is_jmp_o      (br_is_jmp),
        .target_o      (br_target),
        .redirect_o    (br_redirect),
        .redirect_pc_o (br_redirect_pc)
    );

    ex_mul u_mul (
        .ops_i        (ops),
        .mul_result_o (mul_result)
    );

    ex_mem_reg u_mem_reg (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .valid_i          (valid_i),
        .uop_i            (uop_i),
        .rs1_d_i          (rs1_d_i),
        .rs2_d_i          (rs2_d_i),
        .imm_i            (imm_i),
        .rd_we_i          (rd_we_i),
        .rd_a_i           (rd_a_i),
        .alu_result_i     (alu_result),
        .link_result_i    (link_result),
        .mul_result_i     (mul_result),
        .branch_request_i (br_request),
        .branch_taken_i   (br_taken),
        .branch_is_call_i (br_is_call),
        .branch_is_ret_i  (br_is_ret),
        .branch_is_jmp_i  (br_is_jmp),
        .branch_target_i  (br_target),
        .redirect_i       (br_redirect),
        .redirect_pc_i    (br_redirect_pc),
        .valid_o          (valid_o),
        .rd_we_o          (rd_we_o),
        .rd_a_o           (rd_a_o),
        .rd_wd_o          (rd_wd_o),
        .uop_o            (uop_o),
        .mem_a_o          (mem_a_o),
        .mem_wd_o         (mem_wd_o),
        .branch_request_o (branch_request_o),
        .branch_taken_o   (branch_taken_o),
        .branch_is_call_o (branch_is_call_o),
        .branch_is_ret_o  (branch_is_ret_o),
        .branch_is_jmp_o  (branch_is_jmp_o),
        .branch_target_o  (branch_target_o),
        .redirect_o       (redirect_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

// File: sim/ex_stage_sva.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_stage_sva (
    input logic              clk_i,
    input logic              reset_i,
    input logic              valid_i,
    input ex_pkg::uop_e      uop_i,
    input ex_pkg::word_t     pc_i, rs1_d_i, rs2_d_i, imm_i, next_pc_i,
    input logic              next_taken_i, rd_we_i,
    input ex_pkg::reg_addr_t rs1_a_i, rd_a_i,
    input logic              valid_o, rd_we_o,
    input ex_pkg::reg_addr_t rd_a_o,
    input ex_pkg::uop_e      uop_o,
    input ex_pkg::word_t     rd_wd_o, mem_a_o, mem_wd_o, branch_target_o, redirect_pc_o,
    input logic              branch_request_o, branch_taken_o, branch_is_call_o,
    input logic              branch_is_ret_o, branch_is_jmp_o, redirect_o
);
    import ex_pkg::*;

    localparam word_t SIGN = 32'h8000_0000;

    dword_t     sx1, sx2, zx1, zx2;       // sign and zero extended operands
    word_t      link;
    logic       lt_s, lt_u, rd_link, rs1_link;
    word_t      now_wd, now_target, now_rpc, now_mem_a, now_mem_wd;
    logic       now_req, now_taken, now_redir;
    logic [2:0] now_hint;                 // call, ret, jmp
    logic [7:0] ctrl_out;
    logic [7:0] exp_ctrl;
    word_t      exp_wd, exp_target, exp_rpc, exp_mem_a, exp_mem_wd;
    reg_addr_t  exp_rd_a;
    uop_e       exp_uop;
    logic       rst_q = 1'b0;
    logic       armed = 1'b0;             // set by the first reset edge
    logic       fail_flag = 1'b0;
    time        fail_time;
    string      fail_what;
    word_t      fail_exp, fail_got;

    assign sx1      = {{32{rs1_d_i[31]}}, rs1_d_i};
    assign sx2      = {{32{rs2_d_i[31]}}, rs2_d_i};
    assign zx1      = {32'd0, rs1_d_i};
    assign zx2      = {32'd0, rs2_d_i};
    assign link     = pc_i + word_t'(`EX_INSN_STEP);
    assign lt_s     = (rs1_d_i ^ SIGN) < (rs2_d_i ^ SIGN);   // bias trick for signed
    assign lt_u     = rs1_d_i < rs2_d_i;
    assign rd_link  = rd_a_i inside {reg_addr_t'(`EX_LINK_REG_A), reg_addr_t'(`EX_LINK_REG_B)};
    assign rs1_link = rs1_a_i inside {reg_addr_t'(`EX_LINK_REG_A), reg_addr_t'(`EX_LINK_REG_B)};

    always_comb begin
        now_wd     = '0;
        now_req    = 1'b0;
        now_taken  = 1'b0;
        now_hint   = 3'b000;
        now_target = pc_i + imm_i;
        case (uop_i)
            ADDI:   now_wd = rs1_d_i + imm_i;
            ADD:    now_wd = rs1_d_i + rs2_d_i;
            SUB:    now_wd = rs1_d_i + ~rs2_d_i + 32'd1;
            LUI:    now_wd = imm_i;
            AUIPC:  now_wd = pc_i + imm_i;
            SLTI:   now_wd = word_t'((rs1_d_i ^ SIGN) < (imm_i ^ SIGN));
            SLTIU:  now_wd = word_t'(rs1_d_i < imm_i);
            SLT:    now_wd = word_t'(lt_s);
            SLTU:   now_wd = word_t'(lt_u);
            ANDI:   now_wd = rs1_d_i & imm_i;
            ORI:    now_wd = rs1_d_i | imm_i;
            XORI:   now_wd = rs1_d_i ^ imm_i;
            AND:    now_wd = rs1_d_i & rs2_d_i;
            OR:     now_wd = rs1_d_i | rs2_d_i;
            XOR:    now_wd = rs1_d_i ^ rs2_d_i;
            SLLI:   now_wd = rs1_d_i << imm_i[4:0];
            SRLI:   now_wd = rs1_d_i >> imm_i[4:0];
            SRAI:   now_wd = word_t'(sx1 >> imm_i[4:0]);
            SLL:    now_wd = rs1_d_i << rs2_d_i[4:0];
            SRL:    now_wd = rs1_d_i >> rs2_d_i[4:0];
            SRA:    now_wd = word_t'(sx1 >> rs2_d_i[4:0]);
            MUL:    now_wd = word_t'(zx1 * zx2);
            MULH:   now_wd = word_t'((sx1 * sx2) >> 32);
            MULHU:  now_wd = word_t'((zx1 * zx2) >> 32);
            MULHSU: now_wd = word_t'((sx1 * zx2) >> 32);
            JAL: begin
                now_wd    = link;
                now_req   = 1'b1;
                now_taken = 1'b1;
                now_hint  = rd_link ? 3'b100 : 3'b001;
            end
            JALR: begin
                now_wd     = link;
                now_req    = 1'b1;
                now_taken  = 1'b1;
                now_target = rs1_d_i + imm_i;
                now_hint   = {rd_link, rs1_link && !(rd_link && rd_a_i == rs1_a_i),
                              !rd_link && !rs1_link};
            end
            BEQ:  {now_req, now_taken} = {1'b1, rs1_d_i == rs2_d_i};
            BNE:  {now_req, now_taken} = {1'b1, rs1_d_i != rs2_d_i};
            BLT:  {now_req, now_taken} = {1'b1, lt_s};
            BGE:  {now_req, now_taken} = {1'b1, !lt_s};
            BLTU: {now_req, now_taken} = {1'b1, lt_u};
            BGEU: {now_req, now_taken} = {1'b1, !lt_u};
            default: begin
            end
        endcase
    end

    assign now_redir  = now_req && (now_taken ? (!next_taken_i || next_pc_i != now_target)
                                              : next_taken_i);
    assign now_rpc    = now_taken ? now_target : link;
    assign now_mem_a  = (uop_i inside {LB, LH, LW, LBU, LHU, SB, SH, SW}) ? rs1_d_i + imm_i : '0;
    assign now_mem_wd = (uop_i inside {SB, SH, SW}) ? rs2_d_i : '0;

    // expected stage outputs, one cycle behind the inputs
    always_ff @(posedge clk_i) begin
        rst_q      <= reset_i;
        if (reset_i)
            armed <= 1'b1;
        exp_ctrl   <= (reset_i || !valid_i) ? 8'd0
                    : {1'b1, rd_we_i, now_req, now_taken, now_hint, now_redir};
        exp_rd_a   <= rd_a_i;
        exp_uop    <= uop_i;
        exp_wd     <= now_wd;
        exp_target <= now_target;
        exp_rpc    <= now_rpc;
        exp_mem_a  <= now_mem_a;
        exp_mem_wd <= now_mem_wd;
    end

    assign ctrl_out = {valid_o, rd_we_o, branch_request_o, branch_taken_o,
                       branch_is_call_o, branch_is_ret_o, branch_is_jmp_o, redirect_o};

    // keeps the first failure for the testbench
    task automatic record_failure(input string what, input word_t exp, input word_t got);
        if (!fail_flag) begin
            fail_flag = 1'b1;
            fail_time = $time;
            fail_what = what;
            fail_exp  = exp;
            fail_got  = got;
        end
        $error("Mismatch at %0t: %s expected 0x%h got 0x%h", $time, what, exp, got);
    endtask

    a_reset_quiet: assert property (@(posedge clk_i) armed && rst_q |-> ctrl_out == '0)
        else record_failure("control outputs after reset", '0, word_t'($sampled(ctrl_out)));
    a_control: assert property (@(posedge clk_i) armed |-> ctrl_out == exp_ctrl)
        else record_failure("control outputs", word_t'($sampled(exp_ctrl)),
                            word_t'($sampled(ctrl_out)));
    a_result: assert property (@(posedge clk_i) armed && exp_ctrl[7] |-> rd_wd_o == exp_wd)
        else record_failure("rd_wd_o", $sampled(exp_wd), $sampled(rd_wd_o));
    a_rd_addr: assert property (@(posedge clk_i) armed && exp_ctrl[7] |-> rd_a_o == exp_rd_a)
        else record_failure("rd_a_o", word_t'($sampled(exp_rd_a)), word_t'($sampled(rd_a_o)));
    a_uop: assert property (@(posedge clk_i) armed && exp_ctrl[7] |-> uop_o == exp_uop)
        else record_failure("uop_o", word_t'($sampled(exp_uop)), word_t'($sampled(uop_o)));
    a_target: assert property (@(posedge clk_i)
                               armed && exp_ctrl[5] |-> branch_target_o == exp_target)
        else record_failure("branch_target_o", $sampled(exp_target), $sampled(branch_target_o));
    a_redirect_pc: assert property (@(posedge clk_i)
                                    armed && exp_ctrl[0] |-> redirect_pc_o == exp_rpc)
        else record_failure("redirect_pc_o", $sampled(exp_rpc), $sampled(redirect_pc_o));
    a_mem_addr: assert property (@(posedge clk_i) armed && exp_ctrl[7] |-> mem_a_o == exp_mem_a)
        else record_failure("mem_a_o", $sampled(exp_mem_a), $sampled(mem_a_o));
    a_mem_data: assert property (@(posedge clk_i)
                                 armed && exp_ctrl[7] |-> mem_wd_o == exp_mem_wd)
        else record_failure("mem_wd_o", $sampled(exp_mem_wd), $sampled(mem_wd_o));

endmodule

bind ex_stage ex_stage_sva sva0 (.*);

// File: sim/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;
    import ex_pkg::*;

    localparam int RANDOM_CYCLES = 400;
    localparam int QUIET_LIMIT   = 16;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      valid_i;
    uop_e      uop_i;
    word_t     pc_i, rs1_d_i, rs2_d_i, imm_i, next_pc_i;
    logic      next_taken_i, rd_we_i;
    reg_addr_t rs1_a_i, rd_a_i;
    logic      valid_o, rd_we_o;
    reg_addr_t rd_a_o;
    word_t     rd_wd_o, mem_a_o, mem_wd_o, branch_target_o, redirect_pc_o;
    uop_e      uop_o;
    logic      branch_request_o, branch_taken_o, branch_is_call_o;
    logic      branch_is_ret_o, branch_is_jmp_o, redirect_o;
    word_t     cur_pc;                    // pc of the next uop to issue

    always #20 clk_i = ~clk_i;

    ex_stage dut0 (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic drive(input uop_e op, input word_t a, input word_t b, input word_t im,
                         input reg_addr_t ra = '0, input reg_addr_t rd = '0,
                         input logic pred = 1'b0, input word_t npc = '0,
                         input logic v = 1'b1, input logic we = 1'b1);
        @(posedge clk_i);
        #1;
        valid_i      = v;
        rd_we_i      = we;
        uop_i        = op;
        pc_i         = cur_pc;
        rs1_d_i      = a;
        rs2_d_i      = b;
        imm_i        = im;
        rs1_a_i      = ra;
        rd_a_i       = rd;
        next_taken_i = pred;
        next_pc_i    = npc;
        cur_pc       = cur_pc + 32'd4;
    endtask

    task automatic go_idle();
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        uop_i   = NOP;
    endtask

    // inputs are left as they are, so a uop stays on them during reset
    task automatic hold_reset(input int cycles);
        @(posedge clk_i);
        #1;
        reset_i = 1'b1;
        repeat (cycles) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
    endtask

    task automatic wait_quiet();
        int cycles;
        cycles = 0;
        while (valid_o !== 1'b0 && cycles < QUIET_LIMIT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (valid_o !== 1'b0)
            stop_with_failure("Timeout: valid_o stayed high after the input went idle");
    endtask

    function automatic word_t pick_operand();
        case ($urandom_range(0, 5))
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    function automatic reg_addr_t pick_reg();
        return 5'($urandom_range(0, 7));  // low numbers hit x1 and x5 often
    endfunction

    always @(negedge clk_i) begin
        if (dut0.sva0.fail_flag)
            stop_with_failure($sformatf("Mismatch at %0t: %s expected 0x%h got 0x%h",
                dut0.sva0.fail_time, dut0.sva0.fail_what,
                dut0.sva0.fail_exp, dut0.sva0.fail_got));
    end

    initial begin
        uop_e  op;
        word_t a;
        word_t im;
        logic  pred;
        void'($urandom(32'h9475_f87a));
        reset_i      = 1'b1;
        valid_i      = 1'b0;
        uop_i        = NOP;
        pc_i         = '0;
        rs1_d_i      = '0;
        rs2_d_i      = '0;
        imm_i        = '0;
        next_pc_i    = '0;
        next_taken_i = 1'b0;
        rd_we_i      = 1'b0;
        rs1_a_i      = '0;
        rd_a_i       = '0;
        cur_pc       = 32'h0000_1000;
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        drive(ADD,    32'hffff_ffff, 32'd1, '0);
        drive(SUB,    '0, 32'd1, '0);
        drive(SLT,    32'h8000_0000, '0, '0);
        drive(SLTU,   32'h8000_0000, '0, '0);
        drive(SLTI,   32'hffff_ffff, '0, '0);
        drive(SRA,    32'h8000_0000, 32'd31, '0);
        drive(SRAI,   32'h8000_0000, '0, 32'h0000_0fe4);  // only the low 5 bits count
        drive(SLL,    32'hffff_ffff, 32'd36, '0);
        drive(LUI,    '0, '0, 32'hdead_b000);
        drive(AUIPC,  '0, '0, 32'hffff_f000);
        drive(XORI,   32'hffff_ffff, '0, 32'h8000_0000);
        drive(MUL,    32'hffff_ffff, 32'hffff_ffff, '0);
        drive(MULH,   32'h8000_0000, 32'h8000_0000, '0);
        drive(MULH,   32'hffff_ffff, 32'h0000_0007, '0);
        drive(MULHU,  32'hffff_ffff, 32'hffff_ffff, '0);
        drive(MULHSU, 32'hffff_ffff, 32'hffff_ffff, '0);

        // jump hints and predictions
        drive(JAL,  '0, '0, 32'h100, 5'd0, 5'd1, 1'b1, cur_pc + 32'h100);
        drive(JAL,  '0, '0, 32'h100, 5'd0, 5'd0, 1'b0);
        drive(JALR, 32'h2000, '0, 32'h8, 5'd5, 5'd1, 1'b1, 32'h2008);  // pop then push
        drive(JALR, 32'h2000, '0, 32'h8, 5'd1, 5'd1, 1'b1, 32'h2004);  // wrong target
        drive(JALR, 32'h2000, '0, 32'h8, 5'd1, 5'd0);
        drive(JALR, 32'h2000, '0, 32'h8, 5'd2, 5'd5);
        drive(JALR, 32'h2000, '0, 32'h8, 5'd2, 5'd3);

        // branches, right and wrong guesses of direction and target
        drive(BEQ,  32'd7, 32'd7, 32'h40, 5'd0, 5'd0, 1'b1, cur_pc + 32'h40);
        drive(BEQ,  32'd7, 32'd7, 32'h40, 5'd0, 5'd0, 1'b1, cur_pc + 32'h80);
        drive(BNE,  32'd7, 32'd7, 32'h40, 5'd0, 5'd0, 1'b1, cur_pc + 32'h40);
        drive(BLT,  32'h8000_0000, '0, 32'hffff_fff0);
        drive(BGEU, 32'h8000_0000, '0, 32'h20);
        drive(BLTU, 32'h8000_0000, '0, 32'h20);
        drive(BGE,  '0, 32'hffff_ffff, 32'h20, 5'd0, 5'd0, 1'b1, cur_pc + 32'h20);

        drive(LW,  32'h1000, '0, 32'hffff_fffc);
        drive(SW,  32'h1000, 32'hcafe_f00d, 32'h10);
        drive(SB,  32'hffff_ffff, 32'h0000_00a5, 32'd1);
        drive(ADD, 32'h1000, 32'hcafe_f00d, 32'h10, 5'd0, 5'd3, 1'b0, '0, 1'b0);  // bubble

        // reset while a call is on the inputs
        drive(JAL, '0, '0, 32'h100, 5'd0, 5'd1);
        hold_reset(3);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            cur_pc = $urandom() & 32'hffff_fffc;
            op     = uop_e'(6'($urandom_range(0, int'(NOP))));
            a      = pick_operand();
            im     = pick_operand();
            pred   = 1'($urandom_range(0, 1));
            drive(op, a, pick_operand(), im, pick_reg(), pick_reg(), pred,
                  ($urandom_range(0, 1) == 1) ? cur_pc + im : a + im,
                  ($urandom_range(0, 7) != 0), 1'($urandom_range(0, 1)));
        end

        go_idle();
        wait_quiet();
        @(negedge clk_i);
        if (dut0.sva0.fail_flag) begin
            stop_with_failure("Checker flagged a failure at the end of the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: ex_stage.f
+incdir+include
hw/ex_pkg.sv
hw/ex_operand_if.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_mul.sv
hw/ex_mem_reg.sv
hw/ex_stage.sv
sim/ex_stage_sva.sv
sim/ex_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
